// File: filelist.f
src/asg_cfg_pkg.sv
src/asg_bus_pkg.sv
src/asg_regs.sv
src/asg_table.sv
src/asg_seq.sv
src/asg_out.sv
src/asg_top.sv
sim/asg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the signal generator testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module asg_tb \
  --Mdir obj_dir \
  -o asg_sim

status=0
./obj_dir/asg_sim > sim.log 2>&1 || status=$?
cat sim.log
[ "$status" -eq 0 ]

if grep -q "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: sim/asg_tb.sv
`timescale 1ns/1ps

module asg_tb
  import asg_cfg_pkg::*, asg_bus_pkg::*;
;

  // dut ports
  logic          sto;
  logic          ctl_rst;
  logic [TN-1:0] trg_i;
  bus_req_t      bus_req;
  bus_rsp_t      bus_rsp;
  stream_t       sto_str;
  logic          crd_ret = 1'b0;
  logic          trg_o;
  logic          irq_trg;
  logic          irq_stp;

  // table image and the config the reference walks
  sample_t       img [2**CWM];
  asg_cfg_t      ref_cfg;
  // sink state
  bit            hold;
  int unsigned   cyc;
  int unsigned   due_q [$];
  logic [DW:0]   rx_q [$];
  int            n_rx;
  int            n_stp;
  int            rx_idx;
  // bookkeeping
  int            errors;
  int            tests_run;
  int            tests_failed;

  asg_top asg_top_i (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .trg_i   (trg_i),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .sto_str (sto_str),
    .crd_ret (crd_ret),
    .trg_o   (trg_o),
    .irq_trg (irq_trg),
    .irq_stp (irq_stp)
  );

  initial begin
    sto = 1'b0;
    forever #20 sto = ~sto;
  end

  ////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////

  // expected beat k of a sequence, trg on top of the sample
  function automatic logic [DW:0] ref_beat(input int k);
    logic [PW:0] ptr;
    logic [PW:0] lim;
    sample_t     smp;
    int          pos;
    ptr = {1'b0, ref_cfg.off};
    lim = {1'b0, ref_cfg.siz} + (PW+1)'(1);
    smp = '0;
    for (int i = 0; i <= k; i++) begin
      pos = ref_cfg.ben ? i % (int'(ref_cfg.bln) + 1) : 0;
      // each burst period starts over at the offset
      if (ref_cfg.ben && pos == 0) begin
        ptr = {1'b0, ref_cfg.off};
      end
      // idle ticks leave smp at the last data sample
      if (!ref_cfg.ben || pos <= int'(ref_cfg.bdl)) begin
        smp = img[ptr[PW-1:CWF]];
        ptr = ptr + {1'b0, ref_cfg.stp} + (PW+1)'(1);
        if (ptr >= lim) begin
          ptr = ptr - lim;
        end
      end
    end
    return {(k == 0), smp};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // received beats against the reference, in order
  always @(posedge sto) begin : compare_beats
    logic [DW:0] got;
    logic [DW:0] exp;
    while (rx_q.size() != 0) begin
      got = rx_q.pop_front();
      exp = ref_beat(rx_idx);
      check("sto_str.dat", 32'(exp[DW-1:0]), 32'(got[DW-1:0]));
      check("sto_str.trg", 32'(exp[DW]), 32'(got[DW]));
      rx_idx++;
    end
  end

  ////////////////////////////////////////////////////////////
  // sink, credits come back after 0 to 6 cycles
  ////////////////////////////////////////////////////////////

  always @(negedge sto) begin
    if (!ctl_rst && sto_str.vld) begin
      rx_q.push_back({sto_str.trg, sto_str.dat});
      due_q.push_back(cyc + $urandom_range(6, 0));
      n_rx++;
    end
    if (!ctl_rst && irq_stp) begin
      n_stp++;
    end
  end

  // one credit per cycle at most, none while held
  always @(posedge sto) begin : return_credits
    int sel;
    sel = -1;
    if (ctl_rst) begin
      due_q.delete();
    end else if (!hold) begin
      foreach (due_q[i]) begin
        if (sel < 0 && due_q[i] <= cyc) begin
          sel = i;
        end
      end
    end
    if (sel >= 0) begin
      crd_ret <= 1'b1;
      due_q.delete(sel);
    end else begin
      crd_ret <= 1'b0;
    end
    cyc = cyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // bus and trigger tasks
  ////////////////////////////////////////////////////////////

  // one request, ack expected one cycle later
  task automatic bus_op(input logic wr, input logic [AW-1:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    bus_req_t req;
    int       n;
    req.wen   = wr;
    req.ren   = ~wr;
    req.addr  = addr;
    req.wdata = wdata;
    n = 0;
    @(posedge sto);
    bus_req <= req;
    @(posedge sto);
    bus_req <= '0;
    do begin
      @(negedge sto);
      n++;
    end while (!bus_rsp.ack && n < 20);
    if (!bus_rsp.ack) begin
      $display("bus request at %0h got no ack", addr);
      errors++;
    end else begin
      check("bus_rsp.ack delay", 32'd1, 32'(n));
    end
    rdata = bus_rsp.rdata;
  endtask

  function automatic logic [AW-1:0] table_addr(input int i);
    return {1'b1, (AW-1-CWM)'(0), CWM'(i)};
  endfunction

  task automatic write_reg(input logic [RAW-1:0] idx, input logic [31:0] d);
    logic [31:0] rd;
    bus_op(1'b1, AW'(idx), d, rd);
  endtask

  // register read, compared with the field that was written
  task automatic verify_reg(input logic [RAW-1:0] idx, input logic [31:0] exp);
    logic [31:0] rd;
    bus_op(1'b0, AW'(idx), 32'd0, rd);
    check("bus_rsp.rdata", exp, rd);
  endtask

  task automatic apply_cfg(input asg_cfg_t c);
    write_reg(REG_TRG, 32'(c.trg_msk));
    write_reg(REG_SIZ, 32'(c.siz));
    write_reg(REG_STP, 32'(c.stp));
    write_reg(REG_OFF, 32'(c.off));
    write_reg(REG_BCT, {30'd0, c.inf, c.ben});
    write_reg(REG_BDL, 32'(c.bdl));
    write_reg(REG_BLN, c.bln);
    write_reg(REG_BNM, 32'(c.bnm));
    // every field reads back as written
    verify_reg(REG_TRG, 32'(c.trg_msk));
    verify_reg(REG_SIZ, 32'(c.siz));
    verify_reg(REG_STP, 32'(c.stp));
    verify_reg(REG_OFF, 32'(c.off));
    verify_reg(REG_BCT, {30'd0, c.inf, c.ben});
    verify_reg(REG_BDL, 32'(c.bdl));
    verify_reg(REG_BLN, c.bln);
    verify_reg(REG_BNM, 32'(c.bnm));
    ref_cfg = c;
  endtask

  // software stop
  task automatic stop_seq();
    write_reg(REG_CTL, 32'd1);
  endtask

  // irq sampled in the trigger cycle, trg_o one cycle on
  task automatic pulse_trigger(input logic [TN-1:0] v, output logic irq, output logic tro);
    @(posedge sto);
    trg_i <= v;
    @(negedge sto);
    irq = irq_trg;
    @(posedge sto);
    trg_i <= '0;
    @(negedge sto);
    tro = trg_o;
  endtask

  ////////////////////////////////////////////////////////////
  // waits
  ////////////////////////////////////////////////////////////

  task automatic wait_rx(input int target, input int limit);
    int n;
    n = 0;
    while (n_rx < target && n < limit) begin
      @(posedge sto);
      n++;
    end
    if (n_rx < target) begin
      $display("timed out with %0d of %0d beats received", n_rx, target);
      errors++;
    end
  endtask

  task automatic run_cycles(input int cycles);
    int n;
    n = 0;
    while (n < cycles) begin
      @(posedge sto);
      n++;
    end
  endtask

  // no beats, no pending credits, nothing left to compare
  task automatic drain();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < 12 && n < 400) begin
      @(negedge sto);
      n++;
      if (sto_str.vld || due_q.size() != 0 || rx_q.size() != 0) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < 12) begin
      $display("stream did not go quiet within %0d cycles", n);
      errors++;
    end
  endtask

  task automatic report(input int num, input string name, input int e0);
    tests_run++;
    if (errors != e0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd;
    logic        irq;
    logic        tro;
    asg_cfg_t    c;
    int          base;
    int          e0;
    int          s0;
    int          mid;
    void'($urandom(22555));
    ctl_rst = 1'b1;
    trg_i   = '0;
    bus_req = '0;
    hold    = 1'b0;
    ref_cfg = '0;
    run_cycles(10);
    ctl_rst <= 1'b0;

    // table write and read-back
    e0 = errors;
    for (int i = 0; i < 2**CWM; i++) begin
      img[i] = sample_t'($urandom);
      bus_op(1'b1, table_addr(i), 32'(img[i]), rd);
    end
    for (int i = 0; i < 2**CWM; i++) begin
      bus_op(1'b0, table_addr(i), 32'd0, rd);
      check("bus_rsp.rdata", 32'(img[i]), rd);
    end
    report(1, "table write and read-back", e0);

    // periodic, fractional step wraps past 200 entries
    e0 = errors;
    c = '0;
    c.trg_msk = 4'b1111;
    c.siz = 16'hC7FF;
    c.stp = 16'h0A37;
    c.off = 16'h1234;
    apply_cfg(c);
    rx_idx = 0;
    base = n_rx;
    pulse_trigger(4'b0001, irq, tro);
    check("irq_trg", 32'd1, 32'(irq));
    check("trg_o", 32'd1, 32'(tro));
    wait_rx(base + 64, 2000);
    stop_seq();
    drain();
    report(2, "periodic stepping", e0);

    // counted burst, 3 periods of 3 data and 3 idle ticks
    e0 = errors;
    c.siz = 16'h0FFF;
    c.stp = 16'h017F;
    c.off = 16'h0200;
    c.ben = 1'b1;
    c.bdl = 8'd2;
    c.bln = 32'd5;
    c.bnm = 16'd2;
    apply_cfg(c);
    rx_idx = 0;
    base = n_rx;
    s0 = n_stp;
    pulse_trigger(4'b0100, irq, tro);
    wait_rx(base + 18, 1000);
    mid = 0;
    while (n_stp == s0 && mid < 100) begin
      @(posedge sto);
      mid++;
    end
    run_cycles(60);
    check("beat count", 32'd18, 32'(n_rx - base));
    check("irq_stp", 32'd1, 32'(n_stp - s0));
    drain();
    report(3, "counted burst", e0);

    // only input 1 passes the mask
    e0 = errors;
    c.trg_msk = 4'b0010;
    c.siz = 16'hC7FF;
    c.stp = 16'h0A37;
    c.off = 16'h1234;
    c.ben = 1'b0;
    apply_cfg(c);
    rx_idx = 0;
    base = n_rx;
    pulse_trigger(4'b0001, irq, tro);
    check("irq_trg", 32'd0, 32'(irq));
    check("trg_o", 32'd0, 32'(tro));
    run_cycles(30);
    check("beats after masked trigger", 32'd0, 32'(n_rx - base));
    pulse_trigger(4'b0010, irq, tro);
    check("irq_trg", 32'd1, 32'(irq));
    check("trg_o", 32'd1, 32'(tro));
    wait_rx(base + 20, 1000);
    // retrigger while running must not restart the pointer
    pulse_trigger(4'b0010, irq, tro);
    check("irq_trg", 32'd0, 32'(irq));
    wait_rx(base + 60, 2000);
    stop_seq();
    drain();
    report(4, "trigger mask", e0);

    // infinite burst with credits held back
    e0 = errors;
    c.trg_msk = 4'b1111;
    c.siz = 16'h3FFF;
    c.stp = 16'h0250;
    c.off = 16'h0000;
    c.ben = 1'b1;
    c.inf = 1'b1;
    c.bdl = 8'd3;
    c.bln = 32'd6;
    apply_cfg(c);
    rx_idx = 0;
    hold = 1'b1;
    base = n_rx;
    pulse_trigger(4'b1000, irq, tro);
    wait_rx(base + CREDITS, 500);
    run_cycles(60);
    check("beats with credits held", 32'(CREDITS), 32'(n_rx - base));
    hold <= 1'b0;
    wait_rx(base + 40, 2000);
    stop_seq();
    drain();
    report(5, "back-pressure", e0);

    // clr stops the stream, next trigger starts from off
    e0 = errors;
    c.siz = 16'h7FFF;
    c.stp = 16'h0333;
    c.off = 16'h0480;
    c.ben = 1'b0;
    c.inf = 1'b0;
    apply_cfg(c);
    rx_idx = 0;
    base = n_rx;
    pulse_trigger(4'b0001, irq, tro);
    wait_rx(base + 10, 500);
    stop_seq();
    // beats already in flight still land
    run_cycles(8);
    mid = n_rx;
    run_cycles(40);
    check("beats after clr", 32'd0, 32'(n_rx - mid));
    drain();
    rx_idx = 0;
    base = n_rx;
    pulse_trigger(4'b0001, irq, tro);
    check("irq_trg", 32'd1, 32'(irq));
    wait_rx(base + 16, 500);
    stop_seq();
    drain();
    report(6, "software stop", e0);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: src/asg_top.sv
`timescale 1ns/1ps

module asg_top
  import asg_cfg_pkg::*, asg_bus_pkg::*;
(
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic [TN-1:0]  trg_i,
  // cpu bus
  input  bus_req_t       bus_req,
  output bus_rsp_t       bus_rsp,
  // dac stream and credit return
  output stream_t        sto_str,
  input  logic           crd_ret,
  // events
  output logic           trg_o,
  output logic           irq_trg,
  output logic           irq_stp
);

  // registers to sequencer
  asg_cfg_t       cfg;
  logic           clr;
  // cpu table port
  logic           tbl_we;
  logic           tbl_re;
  logic [CWM-1:0] tbl_addr;
  sample_t        tbl_wdat;
  sample_t        tbl_rdat;
  // stream table port
  logic           rd_en;
  logic [CWM-1:0] rd_addr;
  sample_t        rd_dat;
  // sequencer to output stage
  logic           beat_dat_en;
  logic           beat_idle_en;
  logic           seq_trg;
  logic           go;

  ////////////////////////////////////////////////////////////
  // channel
  ////////////////////////////////////////////////////////////

  asg_regs asg_regs_i (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .cfg      (cfg),
    .clr      (clr),
    .tbl_we   (tbl_we),
    .tbl_re   (tbl_re),
    .tbl_addr (tbl_addr),
    .tbl_wdat (tbl_wdat),
    .tbl_rdat (tbl_rdat)
  );

  asg_table asg_table_i (
    .sto      (sto),
    .tbl_we   (tbl_we),
    .tbl_re   (tbl_re),
    .tbl_addr (tbl_addr),
    .tbl_wdat (tbl_wdat),
    .tbl_rdat (tbl_rdat),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_dat   (rd_dat)
  );

  asg_seq asg_seq_i (
    .sto          (sto),
    .ctl_rst      (ctl_rst),
    .clr          (clr),
    .cfg          (cfg),
    .trg_i        (trg_i),
    .go           (go),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .beat_dat_en  (beat_dat_en),
    .beat_idle_en (beat_idle_en),
    .seq_trg      (seq_trg),
    .trg_o        (trg_o),
    .irq_trg      (irq_trg),
    .irq_stp      (irq_stp)
  );

  asg_out asg_out_i (
    .sto          (sto),
    .ctl_rst      (ctl_rst),
    .rd_dat       (rd_dat),
    .beat_dat_en  (beat_dat_en),
    .beat_idle_en (beat_idle_en),
    .seq_trg      (seq_trg),
    .crd_ret      (crd_ret),
    .go           (go),
    .sto_str      (sto_str)
  );

endmodule

// File: src/asg_out.sv
`timescale 1ns/1ps

module asg_out
  import asg_cfg_pkg::*, asg_bus_pkg::*;
(
  input  logic     sto,
  input  logic     ctl_rst,
  input  sample_t  rd_dat,
  input  logic     beat_dat_en,
  input  logic     beat_idle_en,
  input  logic     seq_trg,
  // credit return from the sink
  input  logic     crd_ret,
  output logic     go,
  output stream_t  sto_str
);

  logic           ld;
  logic           vld_q;
  logic           trg_q;
  // last data sample, also what idle beats carry
  sample_t        dat_q;
  logic [CRW-1:0] crd_q;

  // a beat enters the output register
  assign ld = beat_dat_en | beat_idle_en;

  ////////////////////////////////////////////////////////////
  // beat register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_q <= 1'b0;
      trg_q <= 1'b0;
    end else begin
      vld_q <= ld;
      trg_q <= seq_trg;
    end
  end

  // idle beats leave dat_q as it is
  always_ff @(posedge sto) begin
    if (beat_dat_en) begin
      dat_q <= rd_dat;
    end
  end

  assign sto_str.vld = vld_q;
  assign sto_str.dat = dat_q;
  assign sto_str.trg = trg_q;

  ////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////

  // credit taken on load, returned by the sink pulse
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      crd_q <= CRW'(CREDITS);
    end else begin
      crd_q <= crd_q - CRW'(ld) + CRW'(crd_ret);
    end
  end

  // a loading beat still holds its credit this cycle
  assign go = crd_q > CRW'(ld);

  a_crd_max: assert property (@(posedge sto) disable iff (ctl_rst)
    crd_q <= CRW'(CREDITS));

  // sequencer only ticks against a free credit
  a_vld_crd: assert property (@(posedge sto) disable iff (ctl_rst)
    vld_q |-> ($past(crd_q) != '0));

endmodule

// File: src/asg_seq.sv
`timescale 1ns/1ps

module asg_seq
  import asg_cfg_pkg::*;
(
  input  logic            sto,
  input  logic            ctl_rst,
  input  logic            clr,
  input  asg_cfg_t        cfg,
  input  logic [TN-1:0]   trg_i,
  // output stage can take one more tick
  input  logic            go,
  // table read
  output logic            rd_en,
  output logic [CWM-1:0]  rd_addr,
  // ticks toward the output stage, aligned with table data
  output logic            beat_dat_en,
  output logic            beat_idle_en,
  output logic            seq_trg,
  // events
  output logic            trg_o,
  output logic            irq_trg,
  output logic            irq_stp
);

  // state
  logic          run_q;
  logic          first_q;
  logic [PW-1:0] ptr_q;
  logic [31:0]   cnt_q;
  logic [15:0]   rpt_q;
  // trigger
  logic          trg;
  logic          acc;
  // tick decode
  logic          tick;
  logic          dat_ph;
  logic          per_end;
  logic          seq_end;
  // pointer step
  logic [PW:0]   ptr_add;
  logic [PW:0]   ptr_lim;
  logic [PW-1:0] ptr_nxt;

  ////////////////////////////////////////////////////////////
  // trigger
  ////////////////////////////////////////////////////////////

  assign trg = |(trg_i & cfg.trg_msk);
  // ignored while running, stop wins over start
  assign acc = trg & ~run_q & ~clr;

  assign irq_trg = acc;

  ////////////////////////////////////////////////////////////
  // tick decode
  ////////////////////////////////////////////////////////////

  // nothing moves while go is low
  assign tick = run_q & go & ~clr;

  // burst period splits into data ticks then idle ticks
  assign dat_ph  = ~cfg.ben | (cnt_q <= 32'(cfg.bdl));
  assign per_end = cfg.ben & (cnt_q == cfg.bln);
  // last tick of the last counted repetition
  assign seq_end = per_end & ~cfg.inf & (rpt_q == cfg.bnm);

  // modulo step over siz+1
  assign ptr_add = {1'b0, ptr_q} + {1'b0, cfg.stp} + (PW+1)'(1);
  assign ptr_lim = {1'b0, cfg.siz} + (PW+1)'(1);
  assign ptr_nxt = (ptr_add >= ptr_lim) ? PW'(ptr_add - ptr_lim) : ptr_add[PW-1:0];

  assign rd_en   = tick & dat_ph;
  assign rd_addr = ptr_q[PW-1:CWF];

  ////////////////////////////////////////////////////////////
  // run state, counters and pointer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst || clr) begin
      run_q   <= 1'b0;
      first_q <= 1'b0;
      ptr_q   <= '0;
      cnt_q   <= '0;
      rpt_q   <= '0;
    end else if (acc) begin
      // fresh sequence from the offset
      run_q   <= 1'b1;
      first_q <= 1'b1;
      ptr_q   <= cfg.off;
      cnt_q   <= '0;
      rpt_q   <= '0;
    end else if (tick) begin
      first_q <= 1'b0;
      if (per_end) begin
        // next period restarts the pointer
        cnt_q <= '0;
        ptr_q <= cfg.off;
        if (seq_end) begin
          run_q <= 1'b0;
        end else if (!cfg.inf) begin
          rpt_q <= rpt_q + 16'd1;
        end
      end else begin
        if (cfg.ben) begin
          cnt_q <= cnt_q + 32'd1;
        end
        // idle ticks keep the pointer
        if (dat_ph) begin
          ptr_q <= ptr_nxt;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tick and event registers
  ////////////////////////////////////////////////////////////

  // one cycle behind the tick, in step with rd_dat
  always_ff @(posedge sto) begin
    if (ctl_rst || clr) begin
      beat_dat_en  <= 1'b0;
      beat_idle_en <= 1'b0;
      seq_trg      <= 1'b0;
    end else begin
      beat_dat_en  <= tick & dat_ph;
      beat_idle_en <= tick & ~dat_ph;
      seq_trg      <= tick & first_q;
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_o   <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      trg_o   <= acc;
      irq_stp <= tick & seq_end;
    end
  end

  // the wrap keeps the read address inside the programmed table
  a_ptr_range: assert property (@(posedge sto) disable iff (ctl_rst || clr)
    run_q |-> (ptr_q[PW-1:CWF] <= cfg.siz[PW-1:CWF]));

endmodule

// File: src/asg_table.sv
`timescale 1ns/1ps

module asg_table
  import asg_cfg_pkg::*;
(
  input  logic            sto,
  // cpu port
  input  logic            tbl_we,
  input  logic            tbl_re,
  input  logic [CWM-1:0]  tbl_addr,
  input  sample_t         tbl_wdat,
  output sample_t         tbl_rdat,
  // stream port
  input  logic            rd_en,
  input  logic [CWM-1:0]  rd_addr,
  output sample_t         rd_dat
);

  // sample storage, one entry per pointer magnitude
  sample_t mem [2**CWM];

  ////////////////////////////////////////////////////////////
  // cpu write and read-back
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (tbl_we) begin
      mem[tbl_addr] <= tbl_wdat;
    end
  end

  // read-back lands with the bus ack
  always_ff @(posedge sto) begin
    if (tbl_re) begin
      tbl_rdat <= mem[tbl_addr];
    end
  end

  ////////////////////////////////////////////////////////////
  // stream read
  ////////////////////////////////////////////////////////////

  // one cycle latency, held between reads
  always_ff @(posedge sto) begin
    if (rd_en) begin
      rd_dat <= mem[rd_addr];
    end
  end

endmodule

// File: src/asg_regs.sv
`timescale 1ns/1ps

module asg_regs
  import asg_cfg_pkg::*, asg_bus_pkg::*;
(
  input  logic            sto,
  input  logic            ctl_rst,
  // cpu bus
  input  bus_req_t        bus_req,
  output bus_rsp_t        bus_rsp,
  // configuration toward the sequencer
  output asg_cfg_t        cfg,
  output logic            clr,
  // table access
  output logic            tbl_we,
  output logic            tbl_re,
  output logic [CWM-1:0]  tbl_addr,
  output sample_t         tbl_wdat,
  input  sample_t         tbl_rdat
);

  // region decode
  logic           tbl_sel;
  logic           reg_we;
  logic           reg_re;
  logic [RAW-1:0] idx;
  // read path
  logic [31:0]    reg_mux;
  logic [31:0]    rdat_q;
  logic           tbl_sel_q;
  logic           ack_q;

  assign tbl_sel = bus_req.addr[AW-1];
  assign idx     = bus_req.addr[RAW-1:0];
  assign reg_we  = bus_req.wen & ~tbl_sel;
  assign reg_re  = bus_req.ren & ~tbl_sel;

  ////////////////////////////////////////////////////////////
  // table region, forwarded as is
  ////////////////////////////////////////////////////////////

  assign tbl_we   = bus_req.wen & tbl_sel;
  assign tbl_re   = bus_req.ren & tbl_sel;
  assign tbl_addr = bus_req.addr[CWM-1:0];
  assign tbl_wdat = bus_req.wdata[DW-1:0];

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cfg   <= '0;
      clr   <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      // every request is acked next cycle
      ack_q <= bus_req.wen | bus_req.ren;
      // stop pulse, one cycle only
      clr   <= reg_we & (idx == REG_CTL) & bus_req.wdata[0];
      if (reg_we) begin
        case (idx)
          REG_TRG: cfg.trg_msk <= bus_req.wdata[TN-1:0];
          REG_SIZ: cfg.siz     <= bus_req.wdata[PW-1:0];
          REG_STP: cfg.stp     <= bus_req.wdata[PW-1:0];
          REG_OFF: cfg.off     <= bus_req.wdata[PW-1:0];
          REG_BCT: begin
            cfg.ben <= bus_req.wdata[0];
            cfg.inf <= bus_req.wdata[1];
          end
          REG_BDL: cfg.bdl     <= bus_req.wdata[CWM-1:0];
          REG_BLN: cfg.bln     <= bus_req.wdata;
          REG_BNM: cfg.bnm     <= bus_req.wdata[15:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////

  // control word reads as zero
  always_comb begin
    case (idx)
      REG_TRG: reg_mux = 32'(cfg.trg_msk);
      REG_SIZ: reg_mux = 32'(cfg.siz);
      REG_STP: reg_mux = 32'(cfg.stp);
      REG_OFF: reg_mux = 32'(cfg.off);
      REG_BCT: reg_mux = {30'd0, cfg.inf, cfg.ben};
      REG_BDL: reg_mux = 32'(cfg.bdl);
      REG_BLN: reg_mux = cfg.bln;
      REG_BNM: reg_mux = 32'(cfg.bnm);
      default: reg_mux = '0;
    endcase
  end

  always_ff @(posedge sto) begin
    if (reg_re) begin
      rdat_q <= reg_mux;
    end
    if (bus_req.ren) begin
      tbl_sel_q <= tbl_sel;
    end
  end

  // table data is already registered inside the table
  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.rdata = tbl_sel_q ? 32'(tbl_rdat) : rdat_q;

  // bus master issues one kind of request at a time
  a_bus_excl: assert property (@(posedge sto) disable iff (ctl_rst)
    !(bus_req.wen && bus_req.ren));

endmodule

// File: src/asg_bus_pkg.sv
package asg_bus_pkg;

  ////////////////////////////////////////////////////////////
  // cpu register bus
  ////////////////////////////////////////////////////////////

  // word address, top bit selects the table region
  localparam int AW = 16;

  typedef struct packed {
    logic          wen;
    logic          ren;
    logic [AW-1:0] addr;
    logic [31:0]   wdata;
  } bus_req_t;

  // ack one cycle after the request, rdata valid with ack
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////////////////////////////////
  // sample stream toward the dac
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  vld;
    asg_cfg_pkg::sample_t  dat;
    // first beat of a sequence
    logic                  trg;
  } stream_t;

  // credits held by the sink, and the counter width for them
  localparam int CREDITS = 4;
  localparam int CRW     = $clog2(CREDITS + 1);

endpackage

// File: src/asg_cfg_pkg.sv
package asg_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // generator widths
  ////////////////////////////////////////////////////////////

  // trigger inputs
  localparam int TN  = 4;
  // pointer magnitude and fraction, table holds 2**CWM entries
  localparam int CWM = 8;
  localparam int CWF = 8;
  localparam int PW  = CWM + CWF;
  // dac sample
  localparam int DW  = 14;
  // register index width inside the register region
  localparam int RAW = 4;

  typedef logic [DW-1:0] sample_t;

  // channel configuration
  typedef struct packed {
    logic [TN-1:0] trg_msk;
    logic [PW-1:0] siz;
    logic [PW-1:0] stp;
    logic [PW-1:0] off;
    logic          ben;
    logic          inf;
    logic [CWM-1:0] bdl;
    logic [31:0]   bln;
    logic [15:0]   bnm;
  } asg_cfg_t;

  ////////////////////////////////////////////////////////////
  // register word offsets
  ////////////////////////////////////////////////////////////

  localparam logic [RAW-1:0] REG_TRG = 4'd0;
  localparam logic [RAW-1:0] REG_SIZ = 4'd1;
  localparam logic [RAW-1:0] REG_STP = 4'd2;
  localparam logic [RAW-1:0] REG_OFF = 4'd3;
  // bit 0 burst enable, bit 1 infinite
  localparam logic [RAW-1:0] REG_BCT = 4'd4;
  localparam logic [RAW-1:0] REG_BDL = 4'd5;
  localparam logic [RAW-1:0] REG_BLN = 4'd6;
  localparam logic [RAW-1:0] REG_BNM = 4'd7;
  // bit 0 software stop
  localparam logic [RAW-1:0] REG_CTL = 4'd8;

endpackage
